// ==== common/common_pkg.sv ====
package common_pkg;

    // Data word, also the peripheral register width
    typedef logic [31:0] word_t;

    // Byte address within the I/O window, low two bits ignored
    typedef logic [11:0] addr_t;

    // Byte write enables, bit n for byte n
    typedef logic [3:0] mask_t;

    // Request record carried by the request FIFO
    typedef struct packed {
        logic  write;
        addr_t addr;
        word_t wdata;
        mask_t mask;
    } io_req_t;

endpackage

// ==== common/io_map_pkg.sv ====
package io_map_pkg;

    import common_pkg::*;

    // Register locations, compared on the word part only
    localparam addr_t SEG_VALUE_ADDR = 12'h000;
    localparam addr_t TIMER_ADDR     = 12'h004;

    // Read value for anything not mapped
    localparam word_t UNMAPPED_DATA = 32'hDEAD_BEEF;

    // Active-low cathodes {dp, g..a}, dp off
    localparam logic [7:0] SEG_FONT [16] = '{
        8'b1100_0000, 8'b1111_1001, 8'b1010_0100, 8'b1011_0000,
        8'b1001_1001, 8'b1001_0010, 8'b1000_0010, 8'b1111_1000,
        8'b1000_0000, 8'b1001_1000, 8'b1000_1000, 8'b1000_0011,
        8'b1100_0110, 8'b1010_0001, 8'b1000_0110, 8'b1000_1110
    };

endpackage

// ==== rtl/io_credit_fifo.sv ====
module io_credit_fifo #(
    parameter type         payload_t  = logic,
    parameter int unsigned FIFO_DEPTH = 4
) (
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     push_i,
    input  payload_t push_data_i,
    input  logic     pop_i,
    output payload_t pop_data_o,
    output logic     empty_o,
    output logic     full_o
);

    localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);
    localparam int unsigned CNT_W = PTR_W + 1;

    payload_t         mem_r [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr_r;
    logic [PTR_W-1:0] rd_ptr_r;
    logic [CNT_W-1:0] count_r;
    logic             push_w;
    logic             pop_w;

    assign empty_o = (count_r == '0);
    assign full_o  = (count_r == CNT_W'(FIFO_DEPTH));

    // Overflow and underflow are dropped here
    assign push_w = push_i && !full_o;
    assign pop_w  = pop_i && !empty_o;

    // Head entry is visible before the pop
    assign pop_data_o = mem_r[rd_ptr_r];

    always_ff @(posedge clk_i) begin
        if (push_w) begin
            mem_r[wr_ptr_r] <= push_data_i;
        end
    end

    // Depth is a power of two, pointers wrap on their own
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_r <= '0;
            rd_ptr_r <= '0;
            count_r  <= '0;
        end else begin
            wr_ptr_r <= wr_ptr_r + PTR_W'(push_w);
            rd_ptr_r <= rd_ptr_r + PTR_W'(pop_w);
            count_r  <= count_r + CNT_W'(push_w) - CNT_W'(pop_w);
        end
    end

endmodule

// ==== rtl/io_bus_ctrl.sv ====
module io_bus_ctrl
    import common_pkg::*;
    import io_map_pkg::*;
#(
    parameter int unsigned FIFO_DEPTH = 4
) (
    input  logic    clk_i,
    input  logic    rst_i,
    input  logic    req_empty_i,
    input  io_req_t req_data_i,
    output logic    req_pop_o,
    output logic    req_credit_o,
    input  logic    rsp_full_i,
    input  logic    rsp_empty_i,
    output logic    rsp_push_o,
    output word_t   rsp_push_data_o,
    output logic    rsp_pop_o,
    output logic    rsp_valid_o,
    input  logic    rsp_credit_i,
    output word_t   periph_wdata_o,
    output mask_t   seg_mask_o,
    output mask_t   timer_mask_o,
    input  word_t   seg_rdata_i,
    input  word_t   timer_rdata_i
);

    localparam int unsigned CREDIT_W = $clog2(FIFO_DEPTH + 1);

    logic                stg_valid_r;
    logic                stg_write_r;
    logic                stg_seg_r;
    logic                stg_timer_r;
    word_t               stg_wdata_r;
    mask_t               stg_mask_r;
    logic                stg_read_w;
    logic [CREDIT_W-1:0] credits_r;

    assign stg_read_w = stg_valid_r && !stg_write_r;

    // A staged read pushes this cycle and may take the last free slot
    assign req_pop_o    = !req_empty_i && !rsp_full_i && !stg_read_w;
    assign req_credit_o = req_pop_o;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            stg_valid_r <= 1'b0;
        end else begin
            stg_valid_r <= req_pop_o;
        end
    end

    // Decoded request stage
    always_ff @(posedge clk_i) begin
        if (req_pop_o) begin
            stg_write_r <= req_data_i.write;
            stg_seg_r   <= (req_data_i.addr[11:2] == SEG_VALUE_ADDR[11:2]);
            stg_timer_r <= (req_data_i.addr[11:2] == TIMER_ADDR[11:2]);
            stg_wdata_r <= req_data_i.wdata;
            stg_mask_r  <= req_data_i.mask;
        end
    end

    // Write steering, unmapped writes fall through with no mask
    assign periph_wdata_o = stg_wdata_r;
    assign seg_mask_o     = (stg_valid_r && stg_write_r && stg_seg_r) ? stg_mask_r : '0;
    assign timer_mask_o   = (stg_valid_r && stg_write_r && stg_timer_r) ? stg_mask_r : '0;

    assign rsp_push_o      = stg_read_w;
    assign rsp_push_data_o = stg_seg_r   ? seg_rdata_i :
                             stg_timer_r ? timer_rdata_i : UNMAPPED_DATA;

    // Response side, one credit per response handed to the host
    assign rsp_pop_o   = !rsp_empty_i && (credits_r != '0);
    assign rsp_valid_o = rsp_pop_o;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            credits_r <= CREDIT_W'(FIFO_DEPTH);
        end else begin
            credits_r <= credits_r - CREDIT_W'(rsp_pop_o) + CREDIT_W'(rsp_credit_i);
        end
    end

endmodule

// ==== segdisplay/segdisplay.sv ====
module segdisplay
    import common_pkg::*;
    import io_map_pkg::*;
#(
    parameter int unsigned CLK_DIVISOR = 32768
) (
    input  logic       clk_i,
    input  logic       rst_i,
    output logic [7:0] dsp_anode_o,
    output logic [7:0] dsp_cathode_o,
    output word_t      read_data_o,
    input  word_t      write_data_i,
    input  mask_t      write_mask_i
);

    // Top four bits give the digit and its lit or blank phase
    localparam int unsigned COUNTER_W = $clog2(CLK_DIVISOR) + 4;

    logic [COUNTER_W-1:0] scan_r;
    logic [2:0]           digit_w;
    logic                 enable_w;
    word_t                value_r;
    logic [3:0]           nibble_w;
    logic [7:0]           anode_r;
    logic [7:0]           cathode_r;

    assign {digit_w, enable_w} = scan_r[COUNTER_W-1 -: 4];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            scan_r <= '0;
        end else begin
            scan_r <= scan_r + 1'b1;
        end
    end

    // Value register
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            value_r <= '0;
        end else begin
            for (int b = 0; b < 4; b++) begin
                if (write_mask_i[b]) begin
                    value_r[8*b +: 8] <= write_data_i[8*b +: 8];
                end
            end
        end
    end

    assign read_data_o = value_r;

    // Digit 0 is the low nibble
    assign nibble_w = value_r[4*digit_w +: 4];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            anode_r   <= 8'hFF;
            cathode_r <= 8'hFF;
        end else if (enable_w) begin
            anode_r   <= ~(8'b0000_0001 << digit_w);
            cathode_r <= SEG_FONT[nibble_w];
        end else begin
            anode_r   <= 8'hFF;
            cathode_r <= 8'hFF;
        end
    end

    assign dsp_anode_o   = anode_r;
    assign dsp_cathode_o = cathode_r;

endmodule

// ==== rtl/io_timer.sv ====
module io_timer
    import common_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_i,
    output word_t read_data_o,
    input  word_t write_data_i,
    input  mask_t write_mask_i
);

    word_t count_r;

    // Load takes the place of the increment, unwritten bytes hold
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            count_r <= '0;
        end else if (write_mask_i != '0) begin
            for (int b = 0; b < 4; b++) begin
                if (write_mask_i[b]) begin
                    count_r[8*b +: 8] <= write_data_i[8*b +: 8];
                end
            end
        end else begin
            count_r <= count_r + 1'b1;
        end
    end

    assign read_data_o = count_r;

endmodule

// ==== rtl/io_subsys_top.sv ====
module io_subsys_top
    import common_pkg::*;
#(
    parameter int unsigned FIFO_DEPTH  = 4,
    parameter int unsigned CLK_DIVISOR = 32768
) (
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic       req_valid_i,
    input  logic       req_write_i,
    input  addr_t      req_addr_i,
    input  word_t      req_wdata_i,
    input  mask_t      req_mask_i,
    output logic       req_credit_o,
    output logic       rsp_valid_o,
    output word_t      rsp_data_o,
    input  logic       rsp_credit_i,
    output logic [7:0] dsp_anode_o,
    output logic [7:0] dsp_cathode_o
);

    io_req_t req_in;
    io_req_t req_head;
    logic    req_empty;
    logic    req_pop;
    logic    rsp_full;
    logic    rsp_empty;
    logic    rsp_push;
    word_t   rsp_push_data;
    logic    rsp_pop;
    word_t   periph_wdata;
    mask_t   seg_mask;
    mask_t   timer_mask;
    word_t   seg_rdata;
    word_t   timer_rdata;

    assign req_in = '{
        write: req_write_i,
        addr:  req_addr_i,
        wdata: req_wdata_i,
        mask:  req_mask_i
    };

    // Host credits keep this queue from overflowing
    io_credit_fifo #(
        .payload_t (io_req_t),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) i_req_fifo (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .push_i     (req_valid_i),
        .push_data_i(req_in),
        .pop_i      (req_pop),
        .pop_data_o (req_head),
        .empty_o    (req_empty),
        .full_o     ()
    );

    io_credit_fifo #(
        .payload_t (word_t),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) i_rsp_fifo (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .push_i     (rsp_push),
        .push_data_i(rsp_push_data),
        .pop_i      (rsp_pop),
        .pop_data_o (rsp_data_o),
        .empty_o    (rsp_empty),
        .full_o     (rsp_full)
    );

    io_bus_ctrl #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) i_io_bus_ctrl (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .req_empty_i    (req_empty),
        .req_data_i     (req_head),
        .req_pop_o      (req_pop),
        .req_credit_o   (req_credit_o),
        .rsp_full_i     (rsp_full),
        .rsp_empty_i    (rsp_empty),
        .rsp_push_o     (rsp_push),
        .rsp_push_data_o(rsp_push_data),
        .rsp_pop_o      (rsp_pop),
        .rsp_valid_o    (rsp_valid_o),
        .rsp_credit_i   (rsp_credit_i),
        .periph_wdata_o (periph_wdata),
        .seg_mask_o     (seg_mask),
        .timer_mask_o   (timer_mask),
        .seg_rdata_i    (seg_rdata),
        .timer_rdata_i  (timer_rdata)
    );

    segdisplay #(
        .CLK_DIVISOR(CLK_DIVISOR)
    ) i_segdisplay (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .dsp_anode_o  (dsp_anode_o),
        .dsp_cathode_o(dsp_cathode_o),
        .read_data_o  (seg_rdata),
        .write_data_i (periph_wdata),
        .write_mask_i (seg_mask)
    );

    io_timer i_io_timer (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .read_data_o (timer_rdata),
        .write_data_i(periph_wdata),
        .write_mask_i(timer_mask)
    );

endmodule

// ==== verif/io_tb_clock.sv ====
module io_tb_clock (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #20 clk_o = ~clk_o;
    end

    // Reset held for three rising edges
    initial begin
        rst_o = 1'b1;
        repeat (3) @(posedge clk_o);
        #1;
        rst_o = 1'b0;
    end

endmodule

// ==== verif/io_subsys_sva.sv ====
module io_subsys_sva
    import common_pkg::*;
    import io_map_pkg::*;
#(
    parameter int unsigned FIFO_DEPTH = 4
) (
    input logic       clk_i,
    input logic       rst_i,
    input logic       req_valid_i,
    input logic       req_write_i,
    input addr_t      req_addr_i,
    input word_t      req_wdata_i,
    input mask_t      req_mask_i,
    input logic       req_credit_o,
    input logic       rsp_valid_o,
    input word_t      rsp_data_o,
    input logic       rsp_credit_i,
    input logic [7:0] dsp_anode_o,
    input logic [7:0] dsp_cathode_o
);

    int unsigned err_count = 0;

    int         outstanding;
    int         rsp_credits;
    int         idle_cnt;
    word_t      shadow_r;
    addr_t      addr_buf [16];
    word_t      snap_buf [16];
    logic [3:0] wr_idx;
    logic [3:0] rd_idx;
    word_t      last_timer;
    logic       have_timer;
    addr_t      head_addr;
    logic       head_is_seg;
    logic       head_is_timer;
    word_t      exp_data;
    logic       disp_ok;
    logic [3:0] disp_nibble;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            outstanding <= 0;
            rsp_credits <= int'(FIFO_DEPTH);
            idle_cnt    <= 0;
            shadow_r    <= '0;
            wr_idx      <= '0;
            rd_idx      <= '0;
            last_timer  <= '0;
            have_timer  <= 1'b0;
        end else begin
            outstanding <= outstanding + int'(req_valid_i) - int'(req_credit_o);
            rsp_credits <= rsp_credits - int'(rsp_valid_o) + int'(rsp_credit_i);
            if (req_valid_i && req_write_i && req_addr_i[11:2] == SEG_VALUE_ADDR[11:2]) begin
                for (int b = 0; b < 4; b++) begin
                    if (req_mask_i[b]) begin
                        shadow_r[8*b +: 8] <= req_wdata_i[8*b +: 8];
                    end
                end
            end
            // Reads remember the display value as it stands at request time
            if (req_valid_i && !req_write_i) begin
                addr_buf[wr_idx] <= req_addr_i;
                snap_buf[wr_idx] <= shadow_r;
                wr_idx           <= wr_idx + 1'b1;
            end
            if (rsp_valid_o) begin
                rd_idx <= rd_idx + 1'b1;
                if (head_is_timer) begin
                    last_timer <= rsp_data_o;
                    have_timer <= 1'b1;
                end
            end
            if (req_valid_i || outstanding != 0) begin
                idle_cnt <= 0;
            end else if (idle_cnt < 8) begin
                idle_cnt <= idle_cnt + 1;
            end
        end
    end

    always_comb begin
        head_addr     = addr_buf[rd_idx];
        head_is_seg   = (head_addr[11:2] == SEG_VALUE_ADDR[11:2]);
        head_is_timer = (head_addr[11:2] == TIMER_ADDR[11:2]);
        exp_data      = head_is_seg ? snap_buf[rd_idx] : UNMAPPED_DATA;
    end

    // Blank, or one lit digit showing its nibble
    always_comb begin
        disp_ok     = 1'b0;
        disp_nibble = '0;
        if (dsp_anode_o == 8'hFF) begin
            disp_ok = (dsp_cathode_o == 8'hFF);
        end else begin
            for (int d = 0; d < 8; d++) begin
                if (dsp_anode_o == ~(8'(8'h01 << d))) begin
                    disp_nibble = shadow_r[4*d +: 4];
                    disp_ok     = (dsp_cathode_o == SEG_FONT[disp_nibble]);
                end
            end
        end
    end

    reset_state: assert property (@(posedge clk_i)
        rst_i |=> (!rsp_valid_o && !req_credit_o && dsp_anode_o == 8'hFF &&
                   dsp_cathode_o == 8'hFF))
    else begin
        $error("** Error reset rsp_valid_o %h req_credit_o %h dsp_anode_o %h dsp_cathode_o %h",
               rsp_valid_o, req_credit_o, dsp_anode_o, dsp_cathode_o);
        err_count++;
    end

    rsp_needs_credit: assert property (@(posedge clk_i) disable iff (rst_i)
        rsp_valid_o |-> rsp_credits > 0)
    else begin
        $error("response sent while the host held no response credit");
        err_count++;
    end

    outstanding_limit: assert property (@(posedge clk_i) disable iff (rst_i)
        outstanding >= 0 && outstanding <= int'(FIFO_DEPTH))
    else begin
        $error("request credits out of step with the requests sent");
        err_count++;
    end

    rsp_was_requested: assert property (@(posedge clk_i) disable iff (rst_i)
        rsp_valid_o |-> wr_idx != rd_idx)
    else begin
        $error("response arrived with no read outstanding");
        err_count++;
    end

    rsp_data_check: assert property (@(posedge clk_i) disable iff (rst_i)
        (rsp_valid_o && !head_is_timer) |-> rsp_data_o == exp_data)
    else begin
        $error("** Error rsp_data_o %h expected %h", rsp_data_o, exp_data);
        err_count++;
    end

    timer_increases: assert property (@(posedge clk_i) disable iff (rst_i)
        (rsp_valid_o && head_is_timer && have_timer) |-> rsp_data_o > last_timer)
    else begin
        $error("** Error rsp_data_o %h not above previous timer %h", rsp_data_o, last_timer);
        err_count++;
    end

    display_check: assert property (@(posedge clk_i) disable iff (rst_i)
        idle_cnt >= 3 |-> disp_ok)
    else begin
        $error("** Error dsp_anode_o %h dsp_cathode_o %h value %h",
               dsp_anode_o, dsp_cathode_o, shadow_r);
        err_count++;
    end

endmodule

// ==== verif/io_subsys_tb.sv ====
module io_subsys_tb
    import common_pkg::*;
    import io_map_pkg::*;
();

    localparam int unsigned FIFO_DEPTH  = 4;
    localparam int unsigned CLK_DIVISOR = 4;
    localparam int          TIMEOUT     = 2000;

    logic       clk;
    logic       rst;
    logic       req_valid;
    logic       req_write;
    addr_t      req_addr;
    word_t      req_wdata;
    mask_t      req_mask;
    logic       req_credit;
    logic       rsp_valid;
    word_t      rsp_data;
    logic       rsp_credit;
    logic [7:0] anode;
    logic [7:0] cathode;
    int         req_sent;
    int         req_returned;
    int         reads_sent;
    int         rsp_seen;
    int         rsp_returned;
    logic       hold_credits;
    integer     seed;

    bind io_subsys_top io_subsys_sva #(.FIFO_DEPTH(FIFO_DEPTH)) i_io_subsys_sva (.*);

    io_tb_clock i_io_tb_clock (
        .clk_o(clk),
        .rst_o(rst)
    );

    io_subsys_top #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .CLK_DIVISOR(CLK_DIVISOR)
    ) i_io_subsys_top (
        .clk_i        (clk),
        .rst_i        (rst),
        .req_valid_i  (req_valid),
        .req_write_i  (req_write),
        .req_addr_i   (req_addr),
        .req_wdata_i  (req_wdata),
        .req_mask_i   (req_mask),
        .req_credit_o (req_credit),
        .rsp_valid_o  (rsp_valid),
        .rsp_data_o   (rsp_data),
        .rsp_credit_i (rsp_credit),
        .dsp_anode_o  (anode),
        .dsp_cathode_o(cathode)
    );

    task automatic stop_on_timeout(input string what);
        $display("** FAIL **");
        $fatal(1, "timed out waiting for %s", what);
    endtask

    always @(posedge clk) begin
        if (!rst && req_credit) req_returned++;
        if (!rst && rsp_valid) rsp_seen++;
    end

    always @(posedge clk) begin
        if (i_io_subsys_top.i_io_subsys_sva.err_count != 0) begin
            $display("** FAIL **");
            $fatal(1, "assertion failed");
        end
    end

    // Host hands back response credits at random times
    initial begin
        rsp_credit = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            rsp_credit = 1'b0;
            if (!rst && !hold_credits && rsp_seen > rsp_returned && ($random(seed) & 1)) begin
                rsp_credit = 1'b1;
                rsp_returned++;
            end
        end
    end

    task automatic send_req(input logic write, input addr_t addr, input word_t data,
                            input mask_t mask);
        int t;
        t = 0;
        while (req_sent - req_returned >= int'(FIFO_DEPTH)) begin
            @(posedge clk);
            #1;
            t++;
            if (t > TIMEOUT) stop_on_timeout("a request credit");
        end
        req_valid = 1'b1;
        req_write = write;
        req_addr  = addr;
        req_wdata = data;
        req_mask  = mask;
        req_sent++;
        if (!write) reads_sent++;
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    task automatic wait_drained();
        int t;
        t = 0;
        while (req_returned != req_sent || rsp_seen != reads_sent ||
               rsp_returned != rsp_seen) begin
            @(posedge clk);
            #1;
            t++;
            if (t > TIMEOUT) stop_on_timeout("all requests and responses to finish");
        end
    endtask

    initial begin
        int t;
        seed         = 32'h9d23;
        hold_credits = 1'b0;
        req_valid    = 1'b0;
        req_write    = 1'b0;
        req_addr     = '0;
        req_wdata    = '0;
        req_mask     = '0;
        req_sent     = 0;
        req_returned = 0;
        reads_sent   = 0;
        rsp_seen     = 0;
        rsp_returned = 0;
        t = 0;
        @(posedge clk);
        while (rst) begin
            @(posedge clk);
            t++;
            if (t > TIMEOUT) stop_on_timeout("reset release");
        end
        #1;

        // Masked display writes with a read after each
        for (int i = 0; i < 6; i++) begin
            send_req(1'b1, SEG_VALUE_ADDR, $random(seed), $random(seed));
            send_req(1'b0, SEG_VALUE_ADDR, '0, '0);
        end
        send_req(1'b0, 12'h010, '0, '0);
        send_req(1'b0, TIMER_ADDR, '0, '0);
        send_req(1'b0, TIMER_ADDR, '0, '0);
        wait_drained();

        // Read burst with response credits held back
        hold_credits = 1'b1;
        for (int i = 0; i < 12; i++) begin
            case (i % 3)
                0: send_req(1'b0, SEG_VALUE_ADDR, '0, '0);
                1: send_req(1'b0, TIMER_ADDR, '0, '0);
                default: send_req(1'b0, 12'h0F0, '0, '0);
            endcase
        end
        repeat (30) @(posedge clk);
        #1;
        hold_credits = 1'b0;
        wait_drained();

        // Let the scan pass over all eight digits
        send_req(1'b1, SEG_VALUE_ADDR, 32'h89AB_CDEF, 4'hF);
        wait_drained();
        repeat (80) @(posedge clk);
        #1;

        if (i_io_subsys_top.i_io_subsys_sva.err_count == 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            $display("** FAIL **");
            $fatal(1, "assertion failed");
        end
    end

endmodule

// ==== io_subsys.f ====
common/common_pkg.sv
common/io_map_pkg.sv
rtl/io_credit_fifo.sv
rtl/io_bus_ctrl.sv
segdisplay/segdisplay.sv
rtl/io_timer.sv
rtl/io_subsys_top.sv
verif/io_tb_clock.sv
verif/io_subsys_sva.sv
verif/io_subsys_tb.sv

// ==== Bender.yml ====
package:
  name: io_subsys

sources:
  - common/common_pkg.sv
  - common/io_map_pkg.sv
  - rtl/io_credit_fifo.sv
  - rtl/io_bus_ctrl.sv
  - segdisplay/segdisplay.sv
  - rtl/io_timer.sv
  - rtl/io_subsys_top.sv
  - target: test
    files:
      - verif/io_tb_clock.sv
      - verif/io_subsys_sva.sv
      - verif/io_subsys_tb.sv
